//--- rtl/periph_xbar_defines.svh
// Counts, widths and address map of the peripheral crossbar, included by the package and RTL
`ifndef PERIPH_XBAR_DEFINES_SVH
`define PERIPH_XBAR_DEFINES_SVH

// Initiators (cores plus one master peripheral) and targets
`define PX_NB_INPS 4
`define PX_NB_TGTS 4

// Bus widths
`define PX_ADDR_W 32
`define PX_DATA_W 32

// Address bits [31:24] of this cluster
`define PX_CLUSTER_BYTE 8'h10

// Peripheral window on bits [23:20], both ends inclusive
`define PX_PERIPH_LO 2
`define PX_PERIPH_HI 3

// Target select field starts here
`define PX_ROUTE_LSB 16

// Everything outside the window lands on this target
`define PX_EXT_IDX 3

`endif

//--- rtl/periph_xbar_pkg.sv
// Shared bus types of the peripheral crossbar, imported by every RTL module
`include "periph_xbar_defines.svh"

package periph_xbar_pkg;

  typedef logic [`PX_ADDR_W-1:0]          px_addr_t;
  typedef logic [`PX_DATA_W-1:0]          px_data_t;
  typedef logic [`PX_DATA_W/8-1:0]        px_be_t;

  // Binary target select
  typedef logic [$clog2(`PX_NB_TGTS)-1:0] px_idx_t;

  // One bit per initiator, exactly one set on a valid request
  typedef logic [`PX_NB_INPS-1:0]         px_id_t;

  // Arbiter payload, one per initiator
  typedef struct packed {
    px_addr_t addr;
    px_data_t data;
    px_id_t   id;
    logic     we_n;  // Low for a write, as on the core bus
    px_be_t   be;
  } px_req_t;

endpackage

//--- rtl/periph_req_demux.sv
// Per-initiator address decode that steers req to one target and returns its gnt
`timescale 1ns/1ps
`include "periph_xbar_defines.svh"

module periph_req_demux import periph_xbar_pkg::*; (
  input  logic                   req_i,
  input  px_addr_t               addr_i,
  output logic                   gnt_o,
  output logic [`PX_NB_TGTS-1:0] tgt_req_o,
  input  logic [`PX_NB_TGTS-1:0] tgt_gnt_i
);

  logic    in_cluster;
  logic    in_window;
  px_idx_t tgt_idx;

  // Top byte names the cluster
  assign in_cluster = (addr_i[31:24] == `PX_CLUSTER_BYTE);

  // Peripheral region inside the cluster map
  assign in_window = (addr_i[23:20] >= 4'(`PX_PERIPH_LO)) &&
                     (addr_i[23:20] <= 4'(`PX_PERIPH_HI));

  // Local peripherals select on the routing field, the rest go external
  assign tgt_idx = (in_cluster && in_window) ?
                   addr_i[`PX_ROUTE_LSB +: $bits(px_idx_t)] :
                   px_idx_t'(`PX_EXT_IDX);

  // One-hot request toward the decoded target
  always_comb begin
    tgt_req_o          = '0;
    tgt_req_o[tgt_idx] = req_i;
  end

  // Arbiter only grants a requesting input, so no masking needed here
  assign gnt_o = tgt_gnt_i[tgt_idx];

endmodule

//--- rtl/periph_rr_arb.sv
// Per-target round-robin arbiter that forwards the winning initiator's request payload
`timescale 1ns/1ps
`include "periph_xbar_defines.svh"

module periph_rr_arb import periph_xbar_pkg::*; (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic    [`PX_NB_INPS-1:0] req_i,
  input  px_req_t [`PX_NB_INPS-1:0] payload_i,
  output logic    [`PX_NB_INPS-1:0] gnt_o,
  output logic                     req_o,
  output px_req_t                  payload_o,
  input  logic                     gnt_i
);

  localparam int unsigned NB_INPS = `PX_NB_INPS;
  localparam int unsigned IDX_W   = $clog2(NB_INPS);

  typedef logic [IDX_W-1:0] inp_idx_t;

  inp_idx_t rr_ptr_q;
  inp_idx_t rr_ptr_d;
  inp_idx_t win_idx;
  logic     win_found;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    int unsigned cand;
    win_idx   = rr_ptr_q;
    win_found = 1'b0;
    for (int unsigned k = 0; k < NB_INPS; k++) begin
      cand = (int'(rr_ptr_q) + k) % NB_INPS;
      if (!win_found && req_i[cand]) begin
        win_idx   = inp_idx_t'(cand);
        win_found = 1'b1;
      end
    end
  end

  assign req_o     = win_found;
  assign payload_o = payload_i[win_idx];

  // Target grant goes back to the winner alone
  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = gnt_i & win_found;
  end

  // One past the winner
  assign rr_ptr_d = (int'(win_idx) == NB_INPS - 1) ? '0 : inp_idx_t'(win_idx + 1'b1);

  // No lock-in; pointer only moves on an accepted transfer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_ptr_q <= '0;
    end else if (req_o && gnt_i) begin
      rr_ptr_q <= rr_ptr_d;
    end
  end

endmodule

//--- rtl/periph_resp_route.sv
// Per-initiator response select that picks the target answering with this initiator's id
`timescale 1ns/1ps
`include "periph_xbar_defines.svh"

module periph_resp_route import periph_xbar_pkg::*; #(
  parameter int unsigned INP_IDX = 0
) (
  input  logic     [`PX_NB_TGTS-1:0] r_valid_i,
  input  px_id_t   [`PX_NB_TGTS-1:0] r_id_i,
  input  px_data_t [`PX_NB_TGTS-1:0] r_rdata_i,
  input  logic     [`PX_NB_TGTS-1:0] r_opc_i,
  output logic                       r_valid_o,
  output px_data_t                   r_rdata_o,
  output logic                       r_opc_o
);

  localparam px_id_t MY_ID = px_id_t'(1) << INP_IDX;

  logic [`PX_NB_TGTS-1:0] hit;

  for (genvar t = 0; t < `PX_NB_TGTS; t++) begin : gen_hit
    assign hit[t] = r_valid_i[t] && (r_id_i[t] == MY_ID);
  end

  // At most one hit, since each initiator has one request in flight
  always_comb begin
    r_rdata_o = '0;
    r_opc_o   = 1'b0;
    for (int t = `PX_NB_TGTS - 1; t >= 0; t--) begin
      if (hit[t]) begin
        r_rdata_o = r_rdata_i[t];
        r_opc_o   = r_opc_i[t];
      end
    end
  end

  assign r_valid_o = |hit;

endmodule

//--- rtl/periph_xbar.sv
// Top level of the peripheral crossbar joining initiator demuxes, target arbiters and response routes
`timescale 1ns/1ps
`include "periph_xbar_defines.svh"

module periph_xbar import periph_xbar_pkg::*; (
  input  logic                        clk_i,
  input  logic                        arst_n_i,

  // Initiator side
  input  logic     [`PX_NB_INPS-1:0]  init_req_i,
  input  px_addr_t [`PX_NB_INPS-1:0]  init_addr_i,
  input  logic     [`PX_NB_INPS-1:0]  init_wen_i,
  input  px_data_t [`PX_NB_INPS-1:0]  init_wdata_i,
  input  px_be_t   [`PX_NB_INPS-1:0]  init_be_i,
  output logic     [`PX_NB_INPS-1:0]  init_gnt_o,
  output logic     [`PX_NB_INPS-1:0]  init_r_valid_o,
  output px_data_t [`PX_NB_INPS-1:0]  init_r_rdata_o,
  output logic     [`PX_NB_INPS-1:0]  init_r_opc_o,

  // Target side
  output logic     [`PX_NB_TGTS-1:0]  tgt_req_o,
  output px_addr_t [`PX_NB_TGTS-1:0]  tgt_addr_o,
  output logic     [`PX_NB_TGTS-1:0]  tgt_wen_o,
  output px_data_t [`PX_NB_TGTS-1:0]  tgt_wdata_o,
  output px_be_t   [`PX_NB_TGTS-1:0]  tgt_be_o,
  output px_id_t   [`PX_NB_TGTS-1:0]  tgt_id_o,
  input  logic     [`PX_NB_TGTS-1:0]  tgt_gnt_i,
  input  logic     [`PX_NB_TGTS-1:0]  tgt_r_valid_i,
  input  px_data_t [`PX_NB_TGTS-1:0]  tgt_r_rdata_i,
  input  px_id_t   [`PX_NB_TGTS-1:0]  tgt_r_id_i,
  input  logic     [`PX_NB_TGTS-1:0]  tgt_r_opc_i
);

  px_req_t [`PX_NB_INPS-1:0]                  inp_payload;
  logic    [`PX_NB_INPS-1:0][`PX_NB_TGTS-1:0] demux_req;
  logic    [`PX_NB_INPS-1:0][`PX_NB_TGTS-1:0] demux_gnt;

  // Request packing, decode and response return per initiator
  for (genvar i = 0; i < `PX_NB_INPS; i++) begin : gen_inps
    assign inp_payload[i].addr = init_addr_i[i];
    assign inp_payload[i].data = init_wdata_i[i];
    assign inp_payload[i].id   = px_id_t'(1) << i;
    assign inp_payload[i].we_n = init_wen_i[i];
    assign inp_payload[i].be   = init_be_i[i];

    periph_req_demux i_req_demux (
      .req_i     (init_req_i[i]),
      .addr_i    (init_addr_i[i]),
      .gnt_o     (init_gnt_o[i]),
      .tgt_req_o (demux_req[i]),
      .tgt_gnt_i (demux_gnt[i])
    );

    periph_resp_route #(
      .INP_IDX (i)
    ) i_resp_route (
      .r_valid_i (tgt_r_valid_i),
      .r_id_i    (tgt_r_id_i),
      .r_rdata_i (tgt_r_rdata_i),
      .r_opc_i   (tgt_r_opc_i),
      .r_valid_o (init_r_valid_o[i]),
      .r_rdata_o (init_r_rdata_o[i]),
      .r_opc_o   (init_r_opc_o[i])
    );
  end

  // One arbiter per target
  for (genvar t = 0; t < `PX_NB_TGTS; t++) begin : gen_tgts
    logic [`PX_NB_INPS-1:0] arb_req;
    logic [`PX_NB_INPS-1:0] arb_gnt;
    px_req_t                arb_payload;

    // Transpose of the request and grant matrices
    for (genvar j = 0; j < `PX_NB_INPS; j++) begin : gen_cross
      assign arb_req[j]      = demux_req[j][t];
      assign demux_gnt[j][t] = arb_gnt[j];
    end

    periph_rr_arb i_arb (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .req_i     (arb_req),
      .payload_i (inp_payload),
      .gnt_o     (arb_gnt),
      .req_o     (tgt_req_o[t]),
      .payload_o (arb_payload),
      .gnt_i     (tgt_gnt_i[t])
    );

    assign tgt_addr_o[t]  = arb_payload.addr;
    assign tgt_wdata_o[t] = arb_payload.data;
    assign tgt_id_o[t]    = arb_payload.id;
    assign tgt_wen_o[t]   = arb_payload.we_n;
    assign tgt_be_o[t]    = arb_payload.be;
  end

endmodule

//--- tb/periph_xbar_chk.sv
// Concurrent assertions on request steering, target ids and response return, bound to the crossbar
`timescale 1ns/1ps
`include "periph_xbar_defines.svh"

module periph_xbar_chk import periph_xbar_pkg::*; (
  input logic                       clk_i,
  input logic                       arst_n_i,
  input logic     [`PX_NB_TGTS-1:0] tgt_req_i,
  input px_id_t   [`PX_NB_TGTS-1:0] tgt_id_i,
  input logic     [`PX_NB_TGTS-1:0] tgt_r_valid_i,
  input px_id_t   [`PX_NB_TGTS-1:0] tgt_r_id_i,
  input logic     [`PX_NB_INPS-1:0] init_r_valid_i
);

  logic [`PX_NB_INPS-1:0][`PX_NB_TGTS-1:0] inp_on_tgt;
  logic [`PX_NB_INPS-1:0]                  id_returned;
  int unsigned                             fail_cnt = 0;

  // Targets whose forwarded request carries each initiator's id
  always_comb begin
    inp_on_tgt = '0;
    for (int i = 0; i < `PX_NB_INPS; i++) begin
      for (int t = 0; t < `PX_NB_TGTS; t++) begin
        if (tgt_req_i[t] && tgt_id_i[t] == (px_id_t'(1) << i)) begin
          inp_on_tgt[i][t] = 1'b1;
        end
      end
    end
  end

  // Initiators whose exact one-hot id sits on some valid response
  always_comb begin
    id_returned = '0;
    for (int i = 0; i < `PX_NB_INPS; i++) begin
      for (int t = 0; t < `PX_NB_TGTS; t++) begin
        if (tgt_r_valid_i[t] && tgt_r_id_i[t] == (px_id_t'(1) << i)) begin
          id_returned[i] = 1'b1;
        end
      end
    end
  end

  for (genvar i = 0; i < `PX_NB_INPS; i++) begin : gen_inp
    a_one_target : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(inp_on_tgt[i]))
      else begin
        fail_cnt++;
        $error("initiator %0d has a request on more than one target", i);
      end

    a_resp_match : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      init_r_valid_i[i] |-> id_returned[i])
      else begin
        fail_cnt++;
        $error("initiator %0d got r_valid without its id on a target response", i);
      end
  end

  for (genvar t = 0; t < `PX_NB_TGTS; t++) begin : gen_tgt
    a_id_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tgt_req_i[t] |-> $onehot(tgt_id_i[t]))
      else begin
        fail_cnt++;
        $error("target %0d request carries an id that is not one-hot", t);
      end
  end

endmodule

bind periph_xbar periph_xbar_chk i_xbar_chk (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .tgt_req_i      (tgt_req_o),
  .tgt_id_i       (tgt_id_o),
  .tgt_r_valid_i  (tgt_r_valid_i),
  .tgt_r_id_i     (tgt_r_id_i),
  .init_r_valid_i (init_r_valid_o)
);

//--- tb/periph_xbar_tb.sv
// Testbench for the peripheral crossbar; replays the stim file and checks decode, fields and responses
`timescale 1ns/1ps
`include "periph_xbar_defines.svh"

module periph_xbar_tb import periph_xbar_pkg::*; ();

  localparam int       NB_INPS    = `PX_NB_INPS;
  localparam int       NB_TGTS    = `PX_NB_TGTS;
  localparam int       STEP_LIMIT = 64;
  localparam int       BURST_TGT  = 1;
  localparam px_addr_t BURST_ADDR = 32'h1021_0000;

  logic                      clk_i;
  logic                      arst_n_i;
  logic     [NB_INPS-1:0]    init_req_i;
  px_addr_t [NB_INPS-1:0]    init_addr_i;
  logic     [NB_INPS-1:0]    init_wen_i;
  px_data_t [NB_INPS-1:0]    init_wdata_i;
  px_be_t   [NB_INPS-1:0]    init_be_i;
  logic     [NB_INPS-1:0]    init_gnt_o;
  logic     [NB_INPS-1:0]    init_r_valid_o;
  px_data_t [NB_INPS-1:0]    init_r_rdata_o;
  logic     [NB_INPS-1:0]    init_r_opc_o;
  logic     [NB_TGTS-1:0]    tgt_req_o;
  px_addr_t [NB_TGTS-1:0]    tgt_addr_o;
  logic     [NB_TGTS-1:0]    tgt_wen_o;
  px_data_t [NB_TGTS-1:0]    tgt_wdata_o;
  px_be_t   [NB_TGTS-1:0]    tgt_be_o;
  px_id_t   [NB_TGTS-1:0]    tgt_id_o;
  logic     [NB_TGTS-1:0]    tgt_gnt_i     = '0;
  logic     [NB_TGTS-1:0]    tgt_r_valid_i = '0;
  px_data_t [NB_TGTS-1:0]    tgt_r_rdata_i = '0;
  px_id_t   [NB_TGTS-1:0]    tgt_r_id_i    = '0;
  logic     [NB_TGTS-1:0]    tgt_r_opc_i   = '0;

  // Target model state for the request accepted in the last cycle
  logic     [NB_TGTS-1:0]    acc_q      = '0;
  px_addr_t [NB_TGTS-1:0]    acc_addr_q = '0;
  px_id_t   [NB_TGTS-1:0]    acc_id_q   = '0;
  logic                      burst_mode;

  periph_xbar periph_xbar_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Read data holds the address low half, the target index and the initiator index
  function automatic px_data_t model_rdata(int tgt, px_addr_t addr, px_id_t id);
    int inp;
    inp = 0;
    for (int k = 0; k < NB_INPS; k++) begin
      if (id[k]) inp = k;
    end
    return {addr[15:0], 8'(tgt), 8'(inp)};
  endfunction

  always @(posedge clk_i) begin
    acc_q      <= tgt_req_o & tgt_gnt_i;
    acc_addr_q <= tgt_addr_o;
    acc_id_q   <= tgt_id_o;
  end

  // Targets answer one cycle after acceptance; grants are random outside the burst
  always @(negedge clk_i) begin
    logic [31:0] rnd;
    for (int t = 0; t < NB_TGTS; t++) begin
      rnd              = $urandom();
      tgt_r_valid_i[t] = acc_q[t];
      tgt_r_id_i[t]    = acc_id_q[t];
      tgt_r_rdata_i[t] = model_rdata(t, acc_addr_q[t], acc_id_q[t]);
      tgt_gnt_i[t]     = burst_mode ? (t == BURST_TGT) : rnd[0];
    end
  end

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on error");
  endtask

  always @(negedge clk_i) begin
    if (periph_xbar_i.i_xbar_chk.fail_cnt != 0) begin
      $display("A bound assertion on the crossbar failed");
      abort_run();
    end
  end

  task automatic check_addr(string name, px_addr_t exp, px_addr_t got);
    if (got !== exp) begin
      $display("ERR %s expected 0x%h got 0x%h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_data(string name, px_data_t exp, px_data_t got);
    if (got !== exp) begin
      $display("ERR %s expected 0x%h got 0x%h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_idx(string name, px_idx_t exp, px_idx_t got);
    if (got !== exp) begin
      $display("ERR %s expected 0x%h got 0x%h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_id(string name, px_id_t exp, px_id_t got);
    if (got !== exp) begin
      $display("ERR %s expected 0x%h got 0x%h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    arst_n_i = 1'b0;
    repeat (5) @(negedge clk_i);
    arst_n_i = 1'b1;
  endtask

  task automatic wait_timeout(int steps, string what);
    if (steps > STEP_LIMIT) begin
      $display("Timeout while waiting for %s", what);
      abort_run();
    end
  endtask

  // One access from one initiator, checked each cycle until its response
  task automatic do_access(int inp, px_addr_t addr, logic wen, px_data_t wdata, px_idx_t exp_tgt);
    px_be_t  be;
    px_id_t  exp_id;
    px_idx_t got_tgt;
    int      steps;
    logic    done;
    be     = px_be_t'($urandom());
    exp_id = px_id_t'(1) << inp;
    @(negedge clk_i);
    init_req_i[inp]   = 1'b1;
    init_addr_i[inp]  = addr;
    init_wen_i[inp]   = wen;
    init_wdata_i[inp] = wdata;
    init_be_i[inp]    = be;
    done  = 1'b0;
    steps = 0;
    while (!done) begin
      @(posedge clk_i);
      steps++;
      wait_timeout(steps, "a grant");
      if ($countones(tgt_req_o) != 1) begin
        $display("Request did not reach exactly one target (tgt_req_o 0x%h)", tgt_req_o);
        abort_run();
      end
      got_tgt = '0;
      for (int t = 0; t < NB_TGTS; t++) begin
        if (tgt_req_o[t]) got_tgt = px_idx_t'(t);
      end
      check_idx("tgt_req_o index", exp_tgt, got_tgt);
      check_addr("tgt_addr_o", addr, tgt_addr_o[exp_tgt]);
      check_data("tgt_wdata_o", wdata, tgt_wdata_o[exp_tgt]);
      check_data("tgt_wen_o", px_data_t'(wen), px_data_t'(tgt_wen_o[exp_tgt]));
      check_data("tgt_be_o", px_data_t'(be), px_data_t'(tgt_be_o[exp_tgt]));
      check_id("tgt_id_o", exp_id, tgt_id_o[exp_tgt]);
      // Grant only passes through when the target gives it
      check_data("init_gnt_o", px_data_t'(tgt_gnt_i[exp_tgt]), px_data_t'(init_gnt_o[inp]));
      done = init_gnt_o[inp];
    end
    @(negedge clk_i);
    init_req_i[inp] = 1'b0;
    done  = 1'b0;
    steps = 0;
    while (!done) begin
      @(posedge clk_i);
      steps++;
      wait_timeout(steps, "a response");
      check_id("init_r_valid_o", tgt_r_valid_i[exp_tgt] ? exp_id : '0, init_r_valid_o);
      if (tgt_r_valid_i[exp_tgt]) begin
        check_data("init_r_rdata_o", model_rdata(int'(exp_tgt), addr, exp_id),
                   init_r_rdata_o[inp]);
        check_data("init_r_opc_o", '0, px_data_t'(init_r_opc_o[inp]));
        done = 1'b1;
      end
    end
    @(posedge clk_i);
    check_id("init_r_valid_o", '0, init_r_valid_o);
  endtask

  // All initiators hammer one target; accepted ids must rotate from initiator 0
  task automatic run_burst();
    px_id_t done_gnt;
    px_id_t done_rsp;
    int     accepted;
    int     steps;
    burst_mode = 1'b1;
    apply_reset();
    @(negedge clk_i);
    for (int i = 0; i < NB_INPS; i++) begin
      init_addr_i[i]  = BURST_ADDR | px_addr_t'(i << 2);
      init_wen_i[i]   = 1'b1;
      init_wdata_i[i] = '0;
      init_be_i[i]    = '1;
    end
    init_req_i = '1;
    accepted   = 0;
    steps      = 0;
    while (accepted < 2 * NB_INPS) begin
      @(posedge clk_i);
      steps++;
      wait_timeout(steps, "the burst to finish");
      if (tgt_req_o[BURST_TGT] && tgt_gnt_i[BURST_TGT]) begin
        check_id("burst tgt_id_o", px_id_t'(1) << (accepted % NB_INPS), tgt_id_o[BURST_TGT]);
        accepted++;
      end
      done_gnt = init_gnt_o;
      done_rsp = init_r_valid_o;
      @(negedge clk_i);
      init_req_i = (init_req_i & ~done_gnt) | done_rsp;
    end
    init_req_i = '0;
    steps      = 0;
    do begin
      @(posedge clk_i);
      steps++;
      wait_timeout(steps, "burst responses to drain");
    end while (acc_q != '0);
    burst_mode = 1'b0;
  endtask

  initial begin
    string       line;
    int          fd;
    logic [31:0] inp_word;
    logic [31:0] wen_word;
    logic [31:0] tgt_word;
    px_addr_t    addr;
    px_data_t    wdata;
    void'($urandom(32'hac556b6a));
    burst_mode   = 1'b0;
    arst_n_i     = 1'b0;
    init_req_i   = '0;
    init_addr_i  = '0;
    init_wen_i   = '1;
    init_wdata_i = '0;
    init_be_i    = '0;
    apply_reset();
    fd = $fopen("tb/periph_xbar_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      abort_run();
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r") continue;
      if (line[0] == "@") begin
        run_burst();
      end else if ($sscanf(line, "%h %h %h %h %h", inp_word, addr, wen_word, wdata,
                           tgt_word) == 5) begin
        do_access(int'(inp_word), addr, wen_word[0], wdata, px_idx_t'(tgt_word));
      end else begin
        $display("Malformed stimulus line: %s", line);
        abort_run();
      end
    end
    $fclose(fd);
    if (periph_xbar_i.i_xbar_chk.fail_cnt != 0) begin
      $display("A bound assertion on the crossbar failed");
      abort_run();
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

//--- tb/periph_xbar_stim.txt
# Columns (hex): initiator, address, wen (0 = write), write data, expected target
# A line starting with @ runs the round-robin burst on target 1
0 10200000 0 a5a50001 0
1 10210010 1 00000000 1
2 10221234 0 12345678 2
3 1023fffc 1 00000000 3
0 10300040 0 0badcafe 0
1 1031abcd 1 00000000 1
2 10360000 0 00c0ffee 2
3 102d0000 1 00000000 1
0 10100000 1 00000000 3
1 10400000 0 deadbeef 3
2 20200000 1 00000000 3
3 00000000 0 11111111 3
0 ffffffff 1 00000000 3
1 11210000 0 22222222 3
2 10320008 0 cafef00d 2
3 1022ff00 1 00000000 2
0 10230000 0 33333333 3
@burst
1 10210004 1 00000000 1
2 10200100 0 44444444 0
3 10f20000 1 00000000 3

//--- flist.f
+incdir+rtl
rtl/periph_xbar_pkg.sv
rtl/periph_req_demux.sv
rtl/periph_rr_arb.sv
rtl/periph_resp_route.sv
rtl/periph_xbar.sv
tb/periph_xbar_chk.sv
tb/periph_xbar_tb.sv

//--- Makefile
# Verilator build and run of the peripheral crossbar testbench

VERILATOR ?= verilator
TOP       ?= periph_xbar_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
